// ==== src/console_config.svh ====
// build parameters of the serial trace console.
// serial bit period and input record FIFO depth.

`ifndef CONSOLE_CONFIG_SVH
`define CONSOLE_CONFIG_SVH

// clock cycles spent on each serial bit.
// A short period keeps simulation runs brief.
`define CONSOLE_BIT_CYCLES 8

// trace records held ahead of the formatter.
// They absorb bursts from the core while the line drains.
`define CONSOLE_FIFO_DEPTH 4

`endif

// ==== src/console_pkg.sv ====
// shared types of the trace console.
// record kind, payload union, record struct and ASCII constants.

package console_pkg;

    // how the formatter prints one record.
    typedef enum logic {
        TRACE_HEX  = 1'b0,               // four hex digits and a line break.
        TRACE_TEXT = 1'b1                // two raw characters.
    } trace_kind_e;

    // the payload seen as two text characters.
    typedef struct packed {
        logic [7:0] hi;                  // printed first.
        logic [7:0] lo;                  // printed second.
    } trace_chars_s;

    // one 16-bit word with two readings.
    typedef union packed {
        logic [15:0]  value;             // hex reading of the payload.
        trace_chars_s chars;             // text reading of the payload.
    } trace_payload_u;

    // one trace record as handed over by the core.
    typedef struct packed {
        trace_kind_e    kind;            // selects the print format.
        trace_payload_u payload;         // the word to print.
    } trace_rec_s;

    // characters produced by the formatter.
    localparam logic [7:0] CHAR_CR   = 8'h0d;   // carriage return.
    localparam logic [7:0] CHAR_LF   = 8'h0a;   // line feed.
    localparam logic [7:0] CHAR_ZERO = 8'h30;   // ASCII '0'.
    localparam logic [7:0] CHAR_A    = 8'h41;   // upper-case 'A'.

    // a text character of this value is never sent.
    localparam logic [7:0] CHAR_NUL  = 8'h00;

endpackage

// ==== src/trace_fifo.sv ====
// input record FIFO of the trace console.
// circular buffer of records with valid/ready on both sides.

module trace_fifo #(
    parameter int DEPTH = 4                          // records held.
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,         // write side valid.
    input  console_pkg::trace_rec_s i_rec,           // record to store.
    output logic                    o_ready,         // low only when full.
    output logic                    o_valid,         // a record is waiting.
    output console_pkg::trace_rec_s o_rec,           // oldest record.
    input  logic                    i_ready          // read side ready.
);
    import console_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    trace_rec_s       mem [DEPTH];                   // record storage.
    logic [PTR_W-1:0] wr_ptr;                        // next slot to write.
    logic [PTR_W-1:0] rd_ptr;                        // oldest slot.
    logic [CNT_W-1:0] count;                         // records held.
    logic             push;
    logic             pop;

    // pointers wrap at DEPTH so any depth works.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_ready = (count != CNT_W'(DEPTH));       // room for one more record.
    assign o_valid = (count != '0);                  // head of the buffer is live.
    assign o_rec   = mem[rd_ptr];                    // head is read straight out.
    assign push    = i_valid && o_ready;             // write side transfer.
    assign pop     = o_valid && i_ready;             // read side transfer.

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_rec;                    // visible at the output next cycle.
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;               // one record more.
            end else if (pop && !push) begin
                count <= count - 1'b1;               // one record less.
            end
        end
    end

endmodule

// ==== src/trace_formatter.sv ====
// trace record formatter.
// expands one record into hex digits and CR LF, or into its two text characters.

module trace_formatter (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,         // record offered by the FIFO.
    input  console_pkg::trace_rec_s i_rec,           // record to print.
    output logic                    o_ready,         // high while idle.
    output logic                    o_valid,         // character offered.
    output logic [7:0]              o_char,          // character to send.
    input  logic                    i_ready,         // transmitter can take it.
    output logic                    o_active         // a record is being expanded.
);
    import console_pkg::*;

    trace_rec_s rec_q;                               // latched record.
    logic [2:0] idx;                                 // character position in the record.
    logic       active;                              // expansion in progress.
    logic       last;                                // idx points at the final character.
    logic [3:0] nibble;                              // hex digit being printed.
    logic       take_rec;
    logic       take_char;
    logic       rec_has_text;                        // incoming text record prints something.

    assign o_ready   = !active;                      // one record at a time.
    assign o_valid   = active;                       // a character is offered whenever busy.
    assign o_active  = active;
    assign take_rec  = i_valid && o_ready;
    assign take_char = o_valid && i_ready;

    // an all-zero text record has nothing to print.
    assign rec_has_text = (i_rec.payload.chars.hi != CHAR_NUL) ||
                          (i_rec.payload.chars.lo != CHAR_NUL);

    // find the end of the record.
    always_comb begin
        if (rec_q.kind == TRACE_HEX) begin
            last = (idx == 3'd5);                    // LF closes a hex line.
        end else begin
            // a zero low character is skipped so the high one ends the record.
            last = (idx == 3'd1) || (rec_q.payload.chars.lo == CHAR_NUL);
        end
    end

    // pick the character at idx.
    always_comb begin
        nibble = 4'h0;
        o_char = CHAR_CR;
        if (rec_q.kind == TRACE_HEX) begin
            case (idx)
                3'd0:    nibble = rec_q.payload.value[15:12];  // most significant first.
                3'd1:    nibble = rec_q.payload.value[11:8];
                3'd2:    nibble = rec_q.payload.value[7:4];
                default: nibble = rec_q.payload.value[3:0];
            endcase
            if (idx == 3'd4) begin
                o_char = CHAR_CR;
            end else if (idx == 3'd5) begin
                o_char = CHAR_LF;
            end else if (nibble < 4'd10) begin
                o_char = CHAR_ZERO + {4'h0, nibble};           // digits 0 to 9.
            end else begin
                o_char = CHAR_A + {4'h0, nibble - 4'd10};     // letters A to F.
            end
        end else if (idx == 3'd0) begin
            o_char = rec_q.payload.chars.hi;                   // high character goes out first.
        end else begin
            o_char = rec_q.payload.chars.lo;
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_rec) begin
            rec_q <= i_rec;                          // payload held until the last character.
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active <= 1'b0;
            idx    <= 3'd0;
        end else if (take_rec) begin
            // a record with nothing to print is consumed without going active.
            active <= (i_rec.kind == TRACE_HEX) || rec_has_text;
            if ((i_rec.kind == TRACE_TEXT) && (i_rec.payload.chars.hi == CHAR_NUL)) begin
                idx <= 3'd1;                         // skip a zero high character.
            end else begin
                idx <= 3'd0;
            end
        end else if (take_char) begin
            if (last) begin
                active <= 1'b0;                      // idle again after the final transfer.
            end else begin
                idx <= idx + 3'd1;                   // next character offered the cycle after.
            end
        end
    end

endmodule

// ==== src/uart_tx.sv ====
// 8N1 serial transmitter.
// ten-bit frame shifted out LSB first with a per-bit cycle counter.

module uart_tx #(
    parameter int BIT_CYCLES = 8                     // clock cycles per bit.
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_valid,                      // character offered.
    input  logic [7:0] i_char,                       // character to send.
    output logic       o_ready,                      // line is idle.
    output logic       o_txd,                        // serial line out.
    output logic       o_busy                        // a frame is on the line.
);
    localparam int CYC_W = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

    logic [9:0]       shift_q;                       // stop, data and start bits.
    logic [CYC_W-1:0] cyc_q;                         // cycles left in the current bit.
    logic [3:0]       bit_q;                         // bit of the frame on the line.
    logic             busy_q;
    logic             take_char;
    logic             bit_end;

    assign o_ready   = !busy_q;
    assign o_busy    = busy_q;                       // always the inverse of ready.
    assign o_txd     = shift_q[0];                   // idle ones keep the line high.
    assign take_char = i_valid && o_ready;
    assign bit_end   = (cyc_q == '0);                // last cycle of a bit.

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shift_q <= '1;                           // line high out of reset.
            cyc_q   <= '0;
            bit_q   <= 4'd0;
            busy_q  <= 1'b0;
        end else if (take_char) begin
            // start bit in the LSB goes on the line the next cycle.
            shift_q <= {1'b1, i_char, 1'b0};
            cyc_q   <= CYC_W'(BIT_CYCLES - 1);
            bit_q   <= 4'd0;
            busy_q  <= 1'b1;
        end else if (busy_q) begin
            if (bit_end) begin
                shift_q <= {1'b1, shift_q[9:1]};     // next bit and refill with idle ones.
                cyc_q   <= CYC_W'(BIT_CYCLES - 1);   // reload for the next bit.
                if (bit_q == 4'd9) begin
                    busy_q <= 1'b0;                  // stop bit done so ready rises next cycle.
                end else begin
                    bit_q <= bit_q + 4'd1;
                end
            end else begin
                cyc_q <= cyc_q - 1'b1;
            end
        end
    end

endmodule

// ==== src/serial_console.sv ====
// top level of the serial trace console.
// record FIFO, formatter and 8N1 transmitter in a chain.

`include "console_config.svh"

module serial_console (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_rec_valid,     // record offered by the core.
    input  console_pkg::trace_rec_s i_rec,           // trace record.
    output logic                    o_rec_ready,     // low while the FIFO is full.
    output logic                    o_txd,           // serial line.
    output logic                    o_busy           // work still in flight.
);
    import console_pkg::*;

    logic       fifo_valid;                          // FIFO has a record for the formatter.
    trace_rec_s fifo_rec;
    logic       fmt_ready;
    logic       fmt_valid;                           // formatter offers a character.
    logic [7:0] fmt_char;
    logic       fmt_active;
    logic       tx_ready;
    logic       tx_busy;

    trace_fifo #(
        .DEPTH   (`CONSOLE_FIFO_DEPTH)
    ) trace_fifo_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_rec_valid),
        .i_rec   (i_rec),
        .o_ready (o_rec_ready),
        .o_valid (fifo_valid),
        .o_rec   (fifo_rec),
        .i_ready (fmt_ready)
    );

    trace_formatter trace_formatter_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (fifo_valid),
        .i_rec    (fifo_rec),
        .o_ready  (fmt_ready),
        .o_valid  (fmt_valid),
        .o_char   (fmt_char),
        .i_ready  (tx_ready),
        .o_active (fmt_active)
    );

    uart_tx #(
        .BIT_CYCLES (`CONSOLE_BIT_CYCLES)
    ) uart_tx_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (fmt_valid),
        .i_char  (fmt_char),
        .o_ready (tx_ready),
        .o_txd   (o_txd),
        .o_busy  (tx_busy)
    );

    // busy until every stage has drained.
    assign o_busy = fifo_valid || fmt_active || tx_busy;

endmodule

// ==== bench/serial_console_asserts.sv ====
// concurrent checks on the character handshake and the serial line.
// bound into uart_tx and trace_formatter.

module serial_console_asserts #(
    parameter bit HAS_LINE = 1'b1               // the bound stage drives a serial line.
) (
    input logic       i_clk,
    input logic       i_rst_n,
    input logic       i_valid,                  // character offered by the formatter.
    input logic       i_ready,                  // transmitter can take a character.
    input logic [7:0] i_data,                   // character on offer.
    input logic       i_busy,                   // busy flag of the bound stage.
    input logic       i_line                    // serial line of the bound stage.
);
    int unsigned failures = 0;                  // failed checks so far.

    // an offered character holds until the transmitter takes it.
    hold_offer: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_valid && !i_ready) |=> (i_valid && $stable(i_data)))
        else begin
            failures++;
            $error("character offer changed before it was taken");
        end

    // an idle transmitter keeps the line at the mark level.
    if (HAS_LINE) begin : g_line
        idle_line_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            !i_busy |-> i_line)
            else begin
                failures++;
                $error("serial line low while the transmitter is idle");
            end
    end

    quiet_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> (!i_valid && !i_busy))
        else begin
            failures++;
            $error("valid or busy high during reset");
        end

endmodule

// ==== bench/serial_console_tb.sv ====
// testbench of the serial trace console.
// clock, reset, serial line decoder, LFSR, check task and directed tests.

`include "console_config.svh"

module serial_console_tb;
    import console_pkg::*;

    localparam int          BIT_CYCLES   = `CONSOLE_BIT_CYCLES;
    localparam int          FRAME_CYCLES = 10 * BIT_CYCLES;               // one 8N1 character.
    localparam int          WAIT_LIMIT   = (`CONSOLE_FIFO_DEPTH + 12) * 6 * FRAME_CYCLES;
    localparam logic [31:0] LFSR_TAPS    = 32'hb4bcd35c;                  // right-shift form.

    logic        clk;
    logic        rst_n;
    logic        rec_valid;
    trace_rec_s  rec;
    logic        rec_ready;
    logic        txd;
    logic        busy;
    logic [31:0] lfsr_state;
    logic [7:0]  rx_chars [$];                  // characters seen on the line.
    logic [7:0]  exp_chars [$];                 // characters the rules predict.
    logic        line_prev;                     // line level at the previous negedge.
    logic        saw_full;                      // o_rec_ready was seen low.

    serial_console serial_console_i (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_rec_valid (rec_valid),
        .i_rec       (rec),
        .o_rec_ready (rec_ready),
        .o_txd       (txd),
        .o_busy      (busy)
    );

    bind uart_tx serial_console_asserts tx_checks (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_valid (i_valid), .i_ready (o_ready),
        .i_data (i_char), .i_busy (o_busy), .i_line (o_txd)
    );

    bind trace_formatter serial_console_asserts #(.HAS_LINE (1'b0)) fmt_checks (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_valid (o_valid), .i_ready (i_ready),
        .i_data (o_char), .i_busy (o_active), .i_line (1'b1)
    );

    always #2 clk = ~clk;                       // period of 4.

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                                    name, expected, actual));
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;   // feedback folds into the tap bits.
        end
        return state >> 1;
    endfunction

    // each bit taken is the low bit of the state, followed by one LFSR step.
    task automatic take_random_bits(input int count, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic trace_rec_s make_rec(input trace_kind_e kind, input logic [15:0] value);
        trace_rec_s r;
        r.kind          = kind;
        r.payload.value = value;
        return r;
    endfunction

    task automatic expect_text(input string s);
        int i;
        for (i = 0; i < s.len(); i++) begin
            exp_chars.push_back(s[i]);
        end
    endtask

    // predicted line output of one record.
    task automatic append_expansion(input trace_rec_s r);
        string digits;
        int    i;
        digits = "0123456789ABCDEF";
        if (r.kind == TRACE_HEX) begin
            for (i = 3; i >= 0; i--) begin
                exp_chars.push_back(digits[r.payload.value[i*4 +: 4]]);  // high nibble first.
            end
            exp_chars.push_back(8'h0d);
            exp_chars.push_back(8'h0a);
        end else begin
            if (r.payload.value[15:8] != 8'h00) begin
                exp_chars.push_back(r.payload.value[15:8]);
            end
            if (r.payload.value[7:0] != 8'h00) begin
                exp_chars.push_back(r.payload.value[7:0]);
            end
        end
    endtask

    // called one unit after a rising edge, returns one unit after the transfer edge.
    task automatic send_record(input trace_rec_s r);
        int cycles;
        cycles    = 0;
        rec_valid = 1'b1;
        rec       = r;
        @(negedge clk);
        while (!rec_ready) begin
            saw_full = 1'b1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error("a trace record was never accepted by the console");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        rec_valid = 1'b0;
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error({name, ": the console never went idle"});
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic compare_stream(input string name);
        int i;
        check_value({name, " character count"}, exp_chars.size(), rx_chars.size());
        for (i = 0; i < exp_chars.size(); i++) begin
            check_value($sformatf("%s character %0d", name, i), exp_chars[i], rx_chars[i]);
        end
        rx_chars.delete();
        exp_chars.delete();
    endtask

    // entered on the first negedge of a start bit, samples every bit at its middle.
    task automatic decode_frame();
        logic [7:0] data;
        int         i;
        repeat (BIT_CYCLES / 2) @(negedge clk);
        if (txd !== 1'b0) begin
            stop_on_error("start bit went high before its middle");
        end
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            data[i] = txd;                      // LSB arrives first.
        end
        repeat (BIT_CYCLES) @(negedge clk);
        if (txd !== 1'b1) begin
            stop_on_error("stop bit of a received character was low");
        end
        rx_chars.push_back(data);
    endtask

    // the line decoder runs beside the tests and queues every character.
    initial begin
        line_prev = 1'b1;
        forever begin
            @(negedge clk);
            if (rst_n && line_prev && (txd === 1'b0)) begin
                decode_frame();
                line_prev = 1'b1;               // it ended inside a high stop bit.
            end else begin
                line_prev = txd;
            end
        end
    end

    task automatic reset_state_test();
        repeat (20) begin
            @(negedge clk);
            check_value("reset txd", 1, txd);
            check_value("reset busy", 0, busy);
            check_value("reset rec_ready", 1, rec_ready);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic hex_record_test();
        send_record(make_rec(TRACE_HEX, 16'h1a2f));
        wait_idle("hex record");
        expect_text("1A2F");
        exp_chars.push_back(8'h0d);
        exp_chars.push_back(8'h0a);
        compare_stream("hex record");
    endtask

    task automatic text_record_test();
        send_record(make_rec(TRACE_TEXT, 16'h4869));
        send_record(make_rec(TRACE_TEXT, 16'h0041));   // high zero is skipped.
        send_record(make_rec(TRACE_TEXT, 16'h0000));   // consumed without output.
        wait_idle("text records");
        expect_text("HiA");
        compare_stream("text records");
    endtask

    // ten records back to back overrun the FIFO while the line drains.
    task automatic burst_test();
        trace_rec_s  r;
        logic [31:0] bits;
        int          i;
        saw_full = 1'b0;
        for (i = 0; i < 10; i++) begin
            take_random_bits(1, bits);
            r.kind = trace_kind_e'(bits[0]);
            take_random_bits(16, bits);
            r.payload.value = bits[15:0];
            append_expansion(r);
            send_record(r);
        end
        wait_idle("burst");
        check_value("burst o_rec_ready low at least once", 1, saw_full);
        compare_stream("burst");
    endtask

    // 'S' has a set LSB, so the low run is the start bit alone.
    task automatic frame_timing_test();
        logic [9:0] frame;
        int         n;
        int         low_run;
        frame   = {1'b1, 8'h53, 1'b0};
        n       = 0;
        low_run = 0;
        send_record(make_rec(TRACE_TEXT, 16'h5355));
        @(negedge clk);
        while (txd !== 1'b0) begin
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_error("no start bit appeared on the serial line");
            end
            @(negedge clk);
        end
        while ((txd === 1'b0) && (low_run < FRAME_CYCLES)) begin
            low_run++;
            @(negedge clk);
        end
        check_value("start bit length", BIT_CYCLES, low_run);
        // bit sampling ends at the middle of the stop bit so an early next start is seen.
        for (n = BIT_CYCLES; n <= FRAME_CYCLES - BIT_CYCLES / 2; n++) begin
            if ((n % BIT_CYCLES) == (BIT_CYCLES / 2)) begin
                check_value($sformatf("frame bit %0d", n / BIT_CYCLES),
                            frame[n / BIT_CYCLES], txd);
            end
            @(negedge clk);
        end
        while (txd !== 1'b0) begin
            n++;
            if (n > 2 * FRAME_CYCLES) begin
                stop_on_error("second character never started on the line");
            end
            @(negedge clk);
        end
        check_value("start to next start at least ten bits", 1, n >= FRAME_CYCLES);
        wait_idle("frame timing");
        expect_text("SU");
        compare_stream("frame timing");
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b1;
        rec_valid  = 1'b0;
        rec        = '0;
        saw_full   = 1'b0;
        lfsr_state = 32'h83d77d1e;
        #1;
        rst_n = 1'b0;                           // every flop sees this falling edge.
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state_test();
        hex_record_test();
        text_record_test();
        burst_test();
        frame_timing_test();
        if ((serial_console_i.uart_tx_i.tx_checks.failures == 0) &&
            (serial_console_i.trace_formatter_i.fmt_checks.failures == 0)) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_on_error("concurrent assertions failed during the run");
        end
    end

endmodule

// ==== files.f ====
+incdir+src
src/console_pkg.sv
src/trace_fifo.sv
src/trace_formatter.sv
src/uart_tx.sv
src/serial_console.sv
bench/serial_console_asserts.sv
bench/serial_console_tb.sv

// ==== Bender.yml ====
package:
  name: serial_console

sources:
  - include_dirs:
      - src
    files:
      - src/console_pkg.sv
      - src/trace_fifo.sv
      - src/trace_formatter.sv
      - src/uart_tx.sv
      - src/serial_console.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/serial_console_asserts.sv
      - bench/serial_console_tb.sv
